// File: flist.f
+incdir+hdl
hdl/pong_pkg.sv
hdl/sprite_locator.sv
hdl/score_banner.sv
hdl/game_over_art.sv
hdl/pong_pixel_addr.sv
bench/tb_pong_pixel_addr.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the pixel address generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=tb_pong_pixel_addr
build_dir=obj_dir

verilator --binary --timing -f flist.f --top-module "$top" -Mdir "$build_dir"
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_output=$("./$build_dir/V$top" 2>&1)
sim_status=$?
echo "$sim_output"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "test passed" <<< "$sim_output"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

// File: bench/tb_pong_pixel_addr.sv
`include "pong_macros.svh"

module tb_pong_pixel_addr;
    import pong_pkg::*;

    localparam int RANDOM_CYCLES  = 11000;
    localparam int TIMEOUT_CYCLES = 20000;  // About 14000 checked pixels plus reset

    typedef struct packed {
        glyph_t     glyph;
        color_t     color;
        logic [2:0] row;
        logic [2:0] col;
    } expect_t;

    logic        clk = 1'b0;
    logic        reset;
    game_state_t game_state;
    logic [9:0]  hcount;
    logic [9:0]  vcount;
    logic [9:0]  y_pos1;
    logic [9:0]  y_pos2;
    logic [9:0]  ball_x;
    logic [9:0]  ball_y;
    logic [3:0]  tens_score1;
    logic [3:0]  ones_score1;
    logic [3:0]  tens_score2;
    logic [3:0]  ones_score2;
    glyph_t      char_index;
    logic [2:0]  glyph_row;
    logic [2:0]  glyph_column;
    color_t      colors;

    // Staged values copied to the DUT on the falling edge
    logic        stim_reset;
    game_state_t stim_state;
    logic [9:0]  stim_hcount;
    logic [9:0]  stim_vcount;
    logic [9:0]  stim_y_pos1;
    logic [9:0]  stim_y_pos2;
    logic [9:0]  stim_ball_x;
    logic [9:0]  stim_ball_y;
    logic [3:0]  stim_tens1;
    logic [3:0]  stim_ones1;
    logic [3:0]  stim_tens2;
    logic [3:0]  stim_ones2;

    expect_t     expect_q[$];
    expect_t     due;
    int          seed;
    int          cycle_count = 0;

    pong_pixel_addr uut (
        .clk          (clk),
        .reset        (reset),
        .game_state   (game_state),
        .hcount       (hcount),
        .vcount       (vcount),
        .y_pos1       (y_pos1),
        .y_pos2       (y_pos2),
        .ball_x       (ball_x),
        .ball_y       (ball_y),
        .tens_score1  (tens_score1),
        .ones_score1  (ones_score1),
        .tens_score2  (tens_score2),
        .ones_score2  (ones_score2),
        .char_index   (char_index),
        .glyph_row    (glyph_row),
        .glyph_column (glyph_column),
        .colors       (colors)
    );

    always #2 clk = ~clk;

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic covers(input int pos, input int start, input int size);
        return (pos >= start) && (pos < start + size);
    endfunction

    function automatic glyph_t label_char(input int offset, input logic [3:0] tens,
                                          input logic [3:0] ones);
        case (offset)
            0:       return GLYPH_S;
            1:       return GLYPH_C;
            2:       return GLYPH_O;
            3:       return GLYPH_R;
            4:       return GLYPH_E;
            5:       return GLYPH_COLON;
            6:       return glyph_t'(6'(13 + tens));
            default: return glyph_t'(6'(13 + ones));
        endcase
    endfunction

    // Block letters, one grid row per line
    function automatic logic art_solid(input int row, input int col);
        case (row)
            23:      return col inside {48, 49, 53, 54, 57, 61, [63:66]};
            24:      return col inside {47, 50, 52, 55, 57, 58, 60, 61, 63};
            25:      return col inside {47, 52, 55, 57, 59, 61, [63:66]};
            26:      return col inside {47, 49, 50, [52:55], 57, 61, 63};
            27:      return col inside {47, 50, 52, 55, 57, 61, 63};
            28:      return col inside {48, 49, 52, 55, 57, 61, [63:66]};
            30:      return col inside {48, 49, 52, 55, [57:60], [62:64]};
            31:      return col inside {47, 50, 52, 55, 57, 62, 65};
            32:      return col inside {47, 50, 52, 55, [57:60], [62:64]};
            33:      return col inside {47, 50, 52, 55, 57, 62, 65};
            34:      return col inside {47, 50, 52, 55, 57, 62, 65};
            35:      return col inside {48, 49, 53, 54, [57:60], 62, 65};
            default: return 1'b0;
        endcase
    endfunction

    function automatic glyph_t prompt_char(input int col);
        case (col)
            48, 57, 63, 68: return (col == 48) ? GLYPH_P : GLYPH_R;
            49:             return GLYPH_R;
            50, 64:         return GLYPH_E;
            51, 52, 54, 65: return GLYPH_S;
            55, 58, 60:     return GLYPH_T;
            66, 69:         return GLYPH_T;
            56, 67:         return GLYPH_A;
            61:             return GLYPH_O;
            default:        return GLYPH_BLANK;
        endcase
    endfunction

    function automatic expect_t expected_pixel(
        input logic reset_in, input game_state_t state,
        input logic [9:0] h, input logic [9:0] v,
        input logic [9:0] y1, input logic [9:0] y2,
        input logic [9:0] bx, input logic [9:0] by,
        input logic [3:0] t1, input logic [3:0] o1,
        input logic [3:0] t2, input logic [3:0] o2);
        expect_t e;
        int      col;
        int      row;
        col     = int'(h[9:3]);
        row     = int'(v[8:3]);
        e.glyph = GLYPH_BLANK;
        e.color = COLOR_WHITE;
        e.row   = v[2:0];
        e.col   = h[2:0];
        if (!reset_in) begin
            e.row = 3'd0;
            e.col = 3'd0;
        end else if (covers(int'(h), `PADDLE1_LEFT, `PADDLE_WIDTH) &&
                     covers(int'(v), int'(y1), `PADDLE_HEIGHT)) begin
            e.glyph = GLYPH_C;
            e.color = COLOR_P1;
        end else if (covers(int'(h), `PADDLE2_LEFT, `PADDLE_WIDTH) &&
                     covers(int'(v), int'(y2), `PADDLE_HEIGHT)) begin
            e.glyph = GLYPH_C;
            e.color = COLOR_P2;
        end else if (covers(int'(h), int'(bx), `BALL_SIZE) &&
                     covers(int'(v), int'(by), `BALL_SIZE)) begin
            e.glyph = GLYPH_C;
        end else if (row == `SCORE_ROW && covers(col, `SCORE1_COL, 8)) begin
            e.glyph = label_char(col - `SCORE1_COL, t1, o1);
        end else if (row == `SCORE_ROW && covers(col, `SCORE2_COL, 8)) begin
            e.glyph = label_char(col - `SCORE2_COL, t2, o2);
        end else if (state == STATE_OVER && art_solid(row, col)) begin
            e.glyph = GLYPH_SOLID;
        end else if (state == STATE_OVER && row == `TEXT_ROW) begin
            e.glyph = prompt_char(col);
        end
        return e;
    endfunction

    task automatic check_glyph(input glyph_t expected, input glyph_t actual,
                               input logic [2:0] exp_row, input logic [2:0] act_row,
                               input logic [2:0] exp_col, input logic [2:0] act_col);
        if (actual !== expected || act_row !== exp_row || act_col !== exp_col) begin
            if (actual !== expected)
                $display("Mismatch char_index: expected %h, got %h", expected, actual);
            if (act_row !== exp_row)
                $display("Mismatch glyph_row: expected %h, got %h", exp_row, act_row);
            if (act_col !== exp_col)
                $display("Mismatch glyph_column: expected %h, got %h", exp_col, act_col);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_color(input color_t expected, input color_t actual);
        if (actual !== expected) begin
            $display("Mismatch colors: expected %h, got %h", expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic load_inputs();
        reset       = stim_reset;
        game_state  = stim_state;
        hcount      = stim_hcount;
        vcount      = stim_vcount;
        y_pos1      = stim_y_pos1;
        y_pos2      = stim_y_pos2;
        ball_x      = stim_ball_x;
        ball_y      = stim_ball_y;
        tens_score1 = stim_tens1;
        ones_score1 = stim_ones1;
        tens_score2 = stim_tens2;
        ones_score2 = stim_ones2;
        expect_q.push_back(expected_pixel(stim_reset, stim_state, stim_hcount, stim_vcount,
                                          stim_y_pos1, stim_y_pos2, stim_ball_x, stim_ball_y,
                                          stim_tens1, stim_ones1, stim_tens2, stim_ones2));
    endtask

    task automatic apply_cycle();
        @(negedge clk);
        load_inputs();
    endtask

    task automatic random_digits();
        stim_tens1 = 4'(rand_below(10));
        stim_ones1 = 4'(rand_below(10));
        stim_tens2 = 4'(rand_below(10));
        stim_ones2 = 4'(rand_below(10));
    endtask

    task automatic random_inputs();
        stim_state  = game_state_t'(2'(rand_below(4)));
        stim_hcount = 10'(rand_below(1024));
        stim_vcount = 10'(rand_below(1024));
        stim_y_pos1 = 10'(rand_below(1024));
        stim_y_pos2 = 10'(rand_below(1024));
        stim_ball_x = 10'(rand_below(1024));
        stim_ball_y = 10'(rand_below(1024));
        random_digits();
    endtask

    // Pixels just outside, on and at the last inside position of a box
    task automatic sprite_edges(input int left, input int top, input int w, input int h);
        int xs[4];
        int ys[4];
        xs = '{left - 1, left, left + w - 1, left + w};
        ys = '{top - 1, top, top + h - 1, top + h};
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                stim_hcount = 10'(xs[i]);
                stim_vcount = 10'(ys[j]);
                apply_cycle();
            end
        end
    endtask

    task automatic grid_sweep(input game_state_t state, input int row_lo, input int row_hi,
                              input int col_lo, input int col_hi);
        stim_state = state;
        random_digits();
        for (int row = row_lo; row <= row_hi; row++) begin
            for (int col = col_lo; col <= col_hi; col++) begin
                stim_hcount = 10'(col * 8 + rand_below(8));
                stim_vcount = 10'(row * 8 + rand_below(8));
                apply_cycle();
            end
        end
    endtask

    task automatic random_sweep(input int count);
        int mode;
        for (int i = 0; i < count; i++) begin
            random_inputs();
            mode = rand_below(5);
            case (mode)
                1: begin  // Around the ball
                    stim_hcount = 10'(int'(stim_ball_x) + rand_below(12) - 1);
                    stim_vcount = 10'(int'(stim_ball_y) + rand_below(12) - 1);
                end
                2: begin
                    stim_hcount = 10'(`PADDLE1_LEFT - 1 + rand_below(12));
                    stim_vcount = 10'(int'(stim_y_pos1) + rand_below(80) - 2);
                end
                3: begin
                    stim_vcount = 10'(`SCORE_ROW * 8 + rand_below(8));
                end
                4: begin  // Game-over art and prompt
                    stim_hcount = 10'(376 + rand_below(200));
                    stim_vcount = 10'(176 + rand_below(160));
                end
                default: begin
                end
            endcase
            apply_cycle();
        end
    endtask

    always @(posedge clk) begin
        #1;  // Mid high phase once outputs have settled
        if (expect_q.size() > 0) begin
            due = expect_q.pop_front();
            check_glyph(due.glyph, char_index, due.row, glyph_row, due.col, glyph_column);
            check_color(due.color, colors);
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: run went past %0d clock cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $fatal(1);
        end
    end

    initial begin
        seed = 32'h10f71b02;
        random_inputs();
        stim_reset  = 1'b0;
        stim_state  = STATE_PLAY;
        stim_y_pos1 = 10'd100;
        stim_hcount = 10'd155;  // Inside paddle 1 yet blank in reset
        stim_vcount = 10'd110;
        load_inputs();
        repeat (2) begin
            random_inputs();
            apply_cycle();
        end

        stim_reset  = 1'b1;
        stim_state  = STATE_PLAY;
        random_digits();
        stim_y_pos1 = 10'd100;
        stim_y_pos2 = 10'd300;
        stim_ball_x = 10'd400;
        stim_ball_y = 10'd200;
        sprite_edges(`PADDLE1_LEFT, 100, `PADDLE_WIDTH, `PADDLE_HEIGHT);
        sprite_edges(`PADDLE2_LEFT, 300, `PADDLE_WIDTH, `PADDLE_HEIGHT);
        sprite_edges(400, 200, `BALL_SIZE, `BALL_SIZE);
        stim_ball_x = 10'd152;
        stim_ball_y = 10'd120;
        sprite_edges(152, 120, `BALL_SIZE, `BALL_SIZE);
        stim_ball_x = 10'd740;
        stim_ball_y = 10'd330;
        sprite_edges(740, 330, `BALL_SIZE, `BALL_SIZE);
        stim_ball_x = 10'd196;  // Over the player 1 label
        stim_ball_y = 10'd46;
        sprite_edges(196, 46, `BALL_SIZE, `BALL_SIZE);
        stim_y_pos1 = 10'd1000;
        stim_ball_x = 10'd1018;
        stim_ball_y = 10'd1018;
        sprite_edges(`PADDLE1_LEFT, 1000, `PADDLE_WIDTH, `PADDLE_HEIGHT);
        sprite_edges(1018, 1018, `BALL_SIZE, `BALL_SIZE);
        sprite_edges(400, 200, `BALL_SIZE, `BALL_SIZE);

        stim_y_pos1 = 10'd600;
        stim_y_pos2 = 10'd600;
        stim_ball_x = 10'd0;
        stim_ball_y = 10'd0;
        repeat (4) grid_sweep(STATE_PLAY, `SCORE_ROW, `SCORE_ROW, 20, 90);
        grid_sweep(STATE_OVER, 20, 42, 44, 72);
        grid_sweep(STATE_IDLE, 20, 42, 44, 72);
        grid_sweep(STATE_PLAY, 20, 42, 44, 72);

        random_sweep(RANDOM_CYCLES);

        while (expect_q.size() != 0) begin
            @(negedge clk);
        end
        $display("test passed");
        $finish;
    end

endmodule

// File: hdl/pong_pixel_addr.sv
module pong_pixel_addr (
    input  logic                  clk,
    input  logic                  reset,
    input  pong_pkg::game_state_t game_state,
    input  logic [9:0]            hcount,
    input  logic [9:0]            vcount,
    input  logic [9:0]            y_pos1,
    input  logic [9:0]            y_pos2,
    input  logic [9:0]            ball_x,
    input  logic [9:0]            ball_y,
    input  logic [3:0]            tens_score1,
    input  logic [3:0]            ones_score1,
    input  logic [3:0]            tens_score2,
    input  logic [3:0]            ones_score2,
    output pong_pkg::glyph_t      char_index,
    output logic [2:0]            glyph_row,
    output logic [2:0]            glyph_column,
    output pong_pkg::color_t      colors
);
    import pong_pkg::*;

    logic [6:0] grid_column;
    logic [5:0] grid_row;
    logic       paddle1_hit;
    logic       paddle2_hit;
    logic       ball_hit;
    logic       score_hit;
    glyph_t     score_glyph;
    logic       art_hit;
    glyph_t     art_glyph;
    glyph_t     next_index;
    color_t     next_color;

    assign grid_column = hcount[9:3];  // 8x8 cells
    assign grid_row    = vcount[8:3];

    sprite_locator u_sprites (
        .hcount      (hcount),
        .vcount      (vcount),
        .y_pos1      (y_pos1),
        .y_pos2      (y_pos2),
        .ball_x      (ball_x),
        .ball_y      (ball_y),
        .paddle1_hit (paddle1_hit),
        .paddle2_hit (paddle2_hit),
        .ball_hit    (ball_hit)
    );

    score_banner u_score (
        .grid_row    (grid_row),
        .grid_column (grid_column),
        .tens_score1 (tens_score1),
        .ones_score1 (ones_score1),
        .tens_score2 (tens_score2),
        .ones_score2 (ones_score2),
        .score_hit   (score_hit),
        .score_glyph (score_glyph)
    );

    game_over_art u_art (
        .grid_row    (grid_row),
        .grid_column (grid_column),
        .art_hit     (art_hit),
        .art_glyph   (art_glyph)
    );

    // Sprites first, then score, then the game-over screen
    always_comb begin
        next_color = COLOR_WHITE;
        next_index = GLYPH_BLANK;
        if (paddle1_hit) begin
            next_index = GLYPH_C;
            next_color = COLOR_P1;
        end else if (paddle2_hit) begin
            next_index = GLYPH_C;
            next_color = COLOR_P2;
        end else if (ball_hit) begin
            next_index = GLYPH_C;
        end else if (score_hit) begin
            next_index = score_glyph;
        end else if (game_state == STATE_OVER && art_hit) begin
            next_index = art_glyph;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            char_index   <= GLYPH_BLANK;
            colors       <= COLOR_WHITE;
            glyph_row    <= 3'd0;
            glyph_column <= 3'd0;
        end else begin
            char_index   <= next_index;
            colors       <= next_color;
            glyph_row    <= vcount[2:0];  // Aligned with char_index
            glyph_column <= hcount[2:0];
        end
    end

endmodule

// File: hdl/game_over_art.sv
`include "pong_macros.svh"

module game_over_art (
    input  logic [5:0]       grid_row,
    input  logic [6:0]       grid_column,
    output logic             art_hit,
    output pong_pkg::glyph_t art_glyph
);
    import pong_pkg::*;

    logic        in_art_cols;
    logic        in_game;
    logic        in_over;
    logic [2:0]  game_line;
    logic [2:0]  over_line;
    logic [4:0]  art_index;
    logic [0:19] line_mask;
    logic        solid_hit;
    logic        text_hit;
    glyph_t      text_glyph;

    // Bit 0 is column 47, so each literal reads left to right on screen
    function automatic logic [0:19] game_mask(input logic [2:0] line);
        case (line)
            3'd0:    return 20'b0110_0011_0010_0010_1111;
            3'd1:    return 20'b1001_0100_1011_0110_1000;
            3'd2:    return 20'b1000_0100_1010_1010_1111;
            3'd3:    return 20'b1011_0111_1010_0010_1000;
            3'd4:    return 20'b1001_0100_1010_0010_1000;
            3'd5:    return 20'b0110_0100_1010_0010_1111;
            default: return '0;
        endcase
    endfunction

    function automatic logic [0:19] over_mask(input logic [2:0] line);
        case (line)
            3'd0:    return 20'b0110_0100_1011_1101_1100;
            3'd1:    return 20'b1001_0100_1010_0001_0010;
            3'd2:    return 20'b1001_0100_1011_1101_1100;
            3'd3:    return 20'b1001_0100_1010_0001_0010;
            3'd4:    return 20'b1001_0100_1010_0001_0010;
            3'd5:    return 20'b0110_0011_0011_1101_0010;
            default: return '0;
        endcase
    endfunction

    assign in_art_cols = (grid_column >= 7'(`ART_LEFT_COL)) &&
                         (grid_column <= 7'(`ART_RIGHT_COL));
    assign in_game     = (grid_row >= 6'(`GAME_TOP_ROW)) &&
                         (grid_row < 6'(`GAME_TOP_ROW + `ART_LINES));
    assign in_over     = (grid_row >= 6'(`OVER_TOP_ROW)) &&
                         (grid_row < 6'(`OVER_TOP_ROW + `ART_LINES));
    assign game_line   = 3'(grid_row - 6'(`GAME_TOP_ROW));
    assign over_line   = 3'(grid_row - 6'(`OVER_TOP_ROW));
    assign art_index   = 5'(grid_column - 7'(`ART_LEFT_COL));

    always_comb begin
        line_mask = '0;
        if (in_game) begin
            line_mask = game_mask(game_line);
        end else if (in_over) begin
            line_mask = over_mask(over_line);
        end
    end

    assign solid_hit = in_art_cols && line_mask[art_index];

    // PRESS START TO RESTART
    always_comb begin
        case (grid_column)
            7'd48:   text_glyph = GLYPH_P;
            7'd49:   text_glyph = GLYPH_R;
            7'd50:   text_glyph = GLYPH_E;
            7'd51:   text_glyph = GLYPH_S;
            7'd52:   text_glyph = GLYPH_S;
            7'd54:   text_glyph = GLYPH_S;
            7'd55:   text_glyph = GLYPH_T;
            7'd56:   text_glyph = GLYPH_A;
            7'd57:   text_glyph = GLYPH_R;
            7'd58:   text_glyph = GLYPH_T;
            7'd60:   text_glyph = GLYPH_T;
            7'd61:   text_glyph = GLYPH_O;
            7'd63:   text_glyph = GLYPH_R;
            7'd64:   text_glyph = GLYPH_E;
            7'd65:   text_glyph = GLYPH_S;
            7'd66:   text_glyph = GLYPH_T;
            7'd67:   text_glyph = GLYPH_A;
            7'd68:   text_glyph = GLYPH_R;
            7'd69:   text_glyph = GLYPH_T;
            default: text_glyph = GLYPH_BLANK;  // Word gaps too
        endcase
    end

    assign text_hit = (grid_row == 6'(`TEXT_ROW)) && (text_glyph != GLYPH_BLANK);

    // Art and text rows never overlap
    assign art_hit   = solid_hit || text_hit;
    assign art_glyph = solid_hit ? GLYPH_SOLID : (text_hit ? text_glyph : GLYPH_BLANK);

endmodule

// File: hdl/score_banner.sv
`include "pong_macros.svh"

module score_banner (
    input  logic [5:0]       grid_row,
    input  logic [6:0]       grid_column,
    input  logic [3:0]       tens_score1,
    input  logic [3:0]       ones_score1,
    input  logic [3:0]       tens_score2,
    input  logic [3:0]       ones_score2,
    output logic             score_hit,
    output pong_pkg::glyph_t score_glyph
);
    import pong_pkg::*;

    logic       on_row;
    logic       in_label1;
    logic       in_label2;
    logic [2:0] offset1;
    logic [2:0] offset2;

    // "SCORE:" then tens and ones
    function automatic glyph_t label_glyph(input logic [2:0] offset,
                                           input logic [3:0] tens,
                                           input logic [3:0] ones);
        case (offset)
            3'd0:    return GLYPH_S;
            3'd1:    return GLYPH_C;
            3'd2:    return GLYPH_O;
            3'd3:    return GLYPH_R;
            3'd4:    return GLYPH_E;
            3'd5:    return GLYPH_COLON;
            3'd6:    return digit_glyph(tens);
            default: return digit_glyph(ones);
        endcase
    endfunction

    assign on_row    = (grid_row == 6'(`SCORE_ROW));
    assign in_label1 = (grid_column >= 7'(`SCORE1_COL)) &&
                       (grid_column < 7'(`SCORE1_COL + `SCORE_LEN));
    assign in_label2 = (grid_column >= 7'(`SCORE2_COL)) &&
                       (grid_column < 7'(`SCORE2_COL + `SCORE_LEN));
    assign offset1   = 3'(grid_column - 7'(`SCORE1_COL));
    assign offset2   = 3'(grid_column - 7'(`SCORE2_COL));

    always_comb begin
        score_hit   = 1'b0;
        score_glyph = GLYPH_BLANK;
        if (on_row && in_label1) begin
            score_hit   = 1'b1;
            score_glyph = label_glyph(offset1, tens_score1, ones_score1);
        end else if (on_row && in_label2) begin
            score_hit   = 1'b1;
            score_glyph = label_glyph(offset2, tens_score2, ones_score2);
        end
    end

endmodule

// File: hdl/sprite_locator.sv
`include "pong_macros.svh"

module sprite_locator (
    input  logic [9:0] hcount,
    input  logic [9:0] vcount,
    input  logic [9:0] y_pos1,
    input  logic [9:0] y_pos2,
    input  logic [9:0] ball_x,
    input  logic [9:0] ball_y,
    output logic       paddle1_hit,
    output logic       paddle2_hit,
    output logic       ball_hit
);

    // Half-open span test, sums kept 11 bits so edge positions do not wrap
    function automatic logic in_span(input logic [9:0]  pos,
                                     input logic [10:0] start,
                                     input logic [10:0] size);
        logic [10:0] wide_pos;
        wide_pos = {1'b0, pos};
        return (wide_pos >= start) && (wide_pos < start + size);
    endfunction

    assign paddle1_hit = in_span(hcount, 11'(`PADDLE1_LEFT), 11'(`PADDLE_WIDTH)) &&
                         in_span(vcount, {1'b0, y_pos1}, 11'(`PADDLE_HEIGHT));

    assign paddle2_hit = in_span(hcount, 11'(`PADDLE2_LEFT), 11'(`PADDLE_WIDTH)) &&
                         in_span(vcount, {1'b0, y_pos2}, 11'(`PADDLE_HEIGHT));

    assign ball_hit = in_span(hcount, {1'b0, ball_x}, 11'(`BALL_SIZE)) &&
                      in_span(vcount, {1'b0, ball_y}, 11'(`BALL_SIZE));

endmodule

// File: hdl/pong_pkg.sv
package pong_pkg;

    // Value 3 is decoded like play
    typedef enum logic [1:0] {
        STATE_IDLE = 2'd0,
        STATE_PLAY = 2'd1,
        STATE_OVER = 2'd2
    } game_state_t;

    // Character ROM codes
    typedef enum logic [5:0] {
        GLYPH_P      = 6'd0,
        GLYPH_R      = 6'd1,
        GLYPH_E      = 6'd2,
        GLYPH_S      = 6'd3,
        GLYPH_A      = 6'd4,
        GLYPH_T      = 6'd5,
        GLYPH_O      = 6'd6,
        GLYPH_C      = 6'd10,  // Also the sprite fill
        GLYPH_COLON  = 6'd12,
        GLYPH_DIGIT0 = 6'd13,  // Digits 1 to 9 follow
        GLYPH_SOLID  = 6'd30,
        GLYPH_BLANK  = 6'd31
    } glyph_t;

    typedef enum logic [2:0] {
        COLOR_WHITE = 3'd0,
        COLOR_P1    = 3'd1,
        COLOR_P2    = 3'd2
    } color_t;

    // Digit value to its ROM code
    function automatic glyph_t digit_glyph(input logic [3:0] digit);
        return glyph_t'(GLYPH_DIGIT0 + {2'b00, digit});
    endfunction

endpackage

// File: hdl/pong_macros.svh
`ifndef PONG_MACROS_SVH
`define PONG_MACROS_SVH

// Sprite sizes in pixels
`define PADDLE_WIDTH   10
`define PADDLE_HEIGHT  75
`define BALL_SIZE      10

// Fixed paddle columns in pixels
`define PADDLE1_LEFT   150
`define PADDLE2_LEFT   735

// Score banner, in 8x8 cells
`define SCORE_ROW      6
`define SCORE1_COL     24
`define SCORE2_COL     80
`define SCORE_LEN      8

// Game-over text line, in cells
`define TEXT_ROW       40

// Block-letter art, in cells
`define GAME_TOP_ROW   23
`define OVER_TOP_ROW   30
`define ART_LINES      6
`define ART_LEFT_COL   47
`define ART_RIGHT_COL  66

`endif
